/* dg_pkg.sv */
// package: delay/width pair type, register map, bus widths and model constants
package dg_pkg;

   // ================================================
   // bus and data widths
   // ================================================
   localparam int DATA_W = 32;           // register word
   localparam int ADDR_W = 8;            // axi byte address
   localparam int IDX_W  = ADDR_W - 2;   // word index

   localparam int NPAGES = 4;            // protocol pages
   localparam int PAGE_W = 2;            // page / protocol select

   localparam logic [DATA_W-1:0] MODEL_NUMBER = 32'h20210801;
   localparam logic [1:0]        RESP_OKAY    = 2'b00;

   // one output channel, both fields in clk100 cycles from t0
   typedef struct packed {
      logic [31:0] delay;   // rising edge position
      logic [31:0] width;   // high time
   } delay_width_t;

   // ================================================
   // register map, word indices (byte address / 4)
   // ================================================
   localparam logic [IDX_W-1:0] REG_INTERVAL  = IDX_W'(0);   // interval setpoint
   localparam logic [IDX_W-1:0] REG_FLAGS     = IDX_W'(1);   // page select, view bit
   localparam logic [IDX_W-1:0] REG_PROTOCOL  = IDX_W'(2);   // protocol to commit
   localparam logic [IDX_W-1:0] REG_COMMIT    = IDX_W'(3);   // bit 0 commits
   localparam logic [IDX_W-1:0] REG_T0_COUNT  = IDX_W'(4);   // read only
   localparam logic [IDX_W-1:0] REG_TS_LO     = IDX_W'(5);   // read only
   localparam logic [IDX_W-1:0] REG_TS_HI     = IDX_W'(6);   // read only
   localparam logic [IDX_W-1:0] REG_MODEL     = IDX_W'(7);   // read only

   // channel k: delay at base + 2k, width at base + 2k + 1
   localparam logic [IDX_W-1:0] REG_CHAN_BASE = IDX_W'(16);

endpackage

/* cfg_bus_if.sv */
// interface: register write strobe and read-back path between host stage and store
`timescale 1ns/1ps

interface cfg_bus_if
   import dg_pkg::*;
   ();

   logic              wr_valid;   // one cycle per accepted write
   logic [IDX_W-1:0]  wr_index;
   logic [DATA_W-1:0] wr_data;

   logic [IDX_W-1:0]  rd_index;   // follows araddr
   logic [DATA_W-1:0] rd_data;    // combinational from store

   modport host (
      output wr_valid, wr_index, wr_data, rd_index,
      input  rd_data
   );

   modport store (
      input  wr_valid, wr_index, wr_data, rd_index,
      output rd_data
   );

endinterface

/* dg_cfg_if.sv */
// interfaces: dg_cfg_if for the committed set, timer_if for running count and active set
`timescale 1ns/1ps

// committed protocol, level signals sampled by the timer at period start
interface dg_cfg_if
   import dg_pkg::*;
   #(
   parameter int NDELAY_PAIRS = 9
   )
   ();

   delay_width_t [NDELAY_PAIRS-1:0] committed;
   logic [31:0]                     committed_interval;   // already clamped

   modport drv (output committed, committed_interval);
   modport rcv (input  committed, committed_interval);

endinterface

// period position and the set in force for this period
interface timer_if
   import dg_pkg::*;
   #(
   parameter int NDELAY_PAIRS = 9
   )
   ();

   logic [31:0]                     count;          // cycles since period start
   logic                            period_start;   // count is zero
   delay_width_t [NDELAY_PAIRS-1:0] active;

   modport drv (output count, period_start, active);
   modport rcv (input  count, period_start, active);

endinterface

/* axil_regs.sv */
// module: AXI4-Lite slave, byte address to word index, status register read mux
`timescale 1ns/1ps

module axil_regs
   import dg_pkg::*;
   (
   input  logic              clk100,
   input  logic              hps_fpga_reset_n,

   // write address / data / response
   input  logic [ADDR_W-1:0] awaddr,
   input  logic              awvalid,
   output logic              awready,
   input  logic [DATA_W-1:0] wdata,
   input  logic              wvalid,
   output logic              wready,
   output logic [1:0]        bresp,
   output logic              bvalid,
   input  logic              bready,

   // read address / data
   input  logic [ADDR_W-1:0] araddr,
   input  logic              arvalid,
   output logic              arready,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rvalid,
   input  logic              rready,

   cfg_bus_if.host           cfg,

   input  logic [31:0]       t0_count,
   input  logic [63:0]       timestamp
   );

   logic              wr_accept;
   logic              rd_accept;
   logic [IDX_W-1:0]  rd_idx;
   logic [DATA_W-1:0] rd_mux;

   // ================================================
   // write channel
   // ================================================
   assign awready   = ~bvalid;                 // one write in flight
   assign wready    = ~bvalid;
   assign wr_accept = awvalid & wvalid & awready & wready;
   assign bresp     = RESP_OKAY;               // read-only and unmapped too

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         bvalid       <= 1'b0;
         cfg.wr_valid <= 1'b0;
      end else begin
         cfg.wr_valid <= wr_accept;            // strobe one cycle after accept
         if (wr_accept) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;                    // held until host takes it
         end
      end
   end

   always_ff @(posedge clk100) begin
      if (wr_accept) begin
         cfg.wr_index <= awaddr[ADDR_W-1:2];   // byte to word
         cfg.wr_data  <= wdata;
      end
   end

   // ================================================
   // read channel
   // ================================================
   assign arready      = ~rvalid;
   assign rd_accept    = arvalid & arready;
   assign rd_idx       = araddr[ADDR_W-1:2];
   assign cfg.rd_index = rd_idx;               // store answers combinationally
   assign rresp        = RESP_OKAY;

   // status words live here, everything else comes from the store
   always_comb begin
      case (rd_idx)
         REG_T0_COUNT: rd_mux = t0_count;
         REG_TS_LO:    rd_mux = timestamp[31:0];
         REG_TS_HI:    rd_mux = timestamp[63:32];
         REG_MODEL:    rd_mux = MODEL_NUMBER;
         default:      rd_mux = cfg.rd_data;
      endcase
   end

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         rvalid <= 1'b0;
      end else if (rd_accept) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk100) begin
      if (rd_accept) begin
         rdata <= rd_mux;                      // stable while rvalid holds
      end
   end

endmodule

/* protocol_table.sv */
// module: protocol pages, interval setpoint, commit snapshot and read-back view
`timescale 1ns/1ps

module protocol_table
   import dg_pkg::*;
   #(
   parameter int NDELAY_PAIRS     = 9,
   parameter int DEFAULT_INTERVAL = 100000,
   parameter int MIN_INTERVAL     = 1000
   )
   (
   input  logic     clk100,
   input  logic     hps_fpga_reset_n,
   cfg_bus_if.store bus,
   dg_cfg_if.drv    cfg_out
   );

   localparam int                CHAN_W   = (NDELAY_PAIRS > 1) ? $clog2(NDELAY_PAIRS) : 1;
   localparam logic [IDX_W-1:0]  CHAN_END = REG_CHAN_BASE + IDX_W'(2 * NDELAY_PAIRS);
   localparam logic [DATA_W-1:0] MIN_IV   = DATA_W'(MIN_INTERVAL);

   delay_width_t [NDELAY_PAIRS-1:0] pages [NPAGES];   // one page per protocol
   logic [DATA_W-1:0]               interval_set;
   logic [PAGE_W:0]                 flags;            // view bit above page select
   logic [PAGE_W-1:0]               protocol_sel;

   logic                            commit;
   logic                            wr_chan;
   logic [IDX_W-1:0]                wr_off;
   logic [CHAN_W-1:0]               wr_ch;
   logic                            rd_chan;
   logic [IDX_W-1:0]                rd_off;
   logic [CHAN_W-1:0]               rd_ch;
   delay_width_t                    rd_pair;

   // ================================================
   // channel index decode, bit 0 picks delay / width
   // ================================================
   assign wr_chan = (bus.wr_index >= REG_CHAN_BASE) && (bus.wr_index < CHAN_END);
   assign wr_off  = bus.wr_index - REG_CHAN_BASE;
   assign wr_ch   = CHAN_W'(wr_off >> 1);

   assign rd_chan = (bus.rd_index >= REG_CHAN_BASE) && (bus.rd_index < CHAN_END);
   assign rd_off  = bus.rd_index - REG_CHAN_BASE;
   assign rd_ch   = CHAN_W'(rd_off >> 1);

   assign commit  = bus.wr_valid && (bus.wr_index == REG_COMMIT) && bus.wr_data[0];

   // host side registers and edit pages
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int p = 0; p < NPAGES; p++) begin
            pages[p] <= '0;
         end
         interval_set <= '0;
         flags        <= '0;
         protocol_sel <= '0;
      end else if (bus.wr_valid) begin
         case (bus.wr_index)
            REG_INTERVAL: interval_set <= bus.wr_data;
            REG_FLAGS:    flags        <= bus.wr_data[PAGE_W:0];
            REG_PROTOCOL: protocol_sel <= bus.wr_data[PAGE_W-1:0];
            default: begin
               if (wr_chan && wr_off[0]) begin
                  pages[flags[PAGE_W-1:0]][wr_ch].width <= bus.wr_data;
               end else if (wr_chan) begin
                  pages[flags[PAGE_W-1:0]][wr_ch].delay <= bus.wr_data;
               end
            end
         endcase
      end
   end

   // commit snapshot, timer picks it up at the next wrap
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         cfg_out.committed          <= '0;
         cfg_out.committed_interval <= DATA_W'(DEFAULT_INTERVAL);
      end else if (commit) begin
         cfg_out.committed          <= pages[protocol_sel];
         cfg_out.committed_interval <= (interval_set < MIN_IV) ? MIN_IV : interval_set;
      end
   end

   // ================================================
   // read-back, view bit selects committed set
   // ================================================
   assign rd_pair = flags[PAGE_W] ? cfg_out.committed[rd_ch]
                                  : pages[flags[PAGE_W-1:0]][rd_ch];

   always_comb begin
      case (bus.rd_index)
         REG_INTERVAL: bus.rd_data = flags[PAGE_W] ? cfg_out.committed_interval : interval_set;
         REG_FLAGS:    bus.rd_data = DATA_W'(flags);
         REG_PROTOCOL: bus.rd_data = DATA_W'(protocol_sel);
         default: begin
            if (!rd_chan) begin
               bus.rd_data = '0;                  // unmapped
            end else if (rd_off[0]) begin
               bus.rd_data = rd_pair.width;
            end else begin
               bus.rd_data = rd_pair.delay;
            end
         end
      endcase
   end

endmodule

/* period_timer.sv */
// module: period counter, active-set latch, t0 counter and cycle timestamp
`timescale 1ns/1ps

module period_timer
   import dg_pkg::*;
   #(
   parameter int NDELAY_PAIRS     = 9,
   parameter int DEFAULT_INTERVAL = 100000
   )
   (
   input  logic        clk100,
   input  logic        hps_fpga_reset_n,
   dg_cfg_if.rcv       cfg_in,
   timer_if.drv        tmr,
   output logic [31:0] t0_count,
   output logic [63:0] timestamp
   );

   delay_width_t [NDELAY_PAIRS-1:0] active_q;   // set in force this period
   logic [31:0]                     count;
   logic [31:0]                     interval_act;
   logic [63:0]                     cycle_cnt;     // free running
   logic                            wrap;

   assign wrap             = (count == interval_act - 32'd1);
   assign tmr.count        = count;
   assign tmr.period_start = (count == '0);
   assign tmr.active       = active_q;

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 64'd1;
      end
   end

   // ================================================
   // period counter, commit takes effect on wrap
   // ================================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         count        <= 32'(DEFAULT_INTERVAL - 1);   // first cycle out of reset wraps
         interval_act <= 32'(DEFAULT_INTERVAL);
         active_q     <= '0;
         t0_count     <= '0;
         timestamp    <= '0;
      end else if (wrap) begin
         count        <= '0;
         interval_act <= cfg_in.committed_interval;
         active_q     <= cfg_in.committed;
         t0_count     <= t0_count + 32'd1;
         timestamp    <= cycle_cnt;                   // seen from period start on
      end else begin
         count <= count + 32'd1;
      end
   end

endmodule

/* pulse_channels.sv */
// module: per-channel window compare against the period count, registered pins and t0
`timescale 1ns/1ps

module pulse_channels #(
   parameter int NDELAY_PAIRS = 9
   )
   (
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,
   timer_if.rcv                    tmr,
   output logic                    t0,
   output logic [NDELAY_PAIRS-1:0] pins
   );

   logic [NDELAY_PAIRS-1:0] hit;

   // delay <= count < delay + width, without a 33-bit sum
   for (genvar k = 0; k < NDELAY_PAIRS; k++) begin : g_chan
      logic [31:0] since;   // cycles past the delay
      assign since  = tmr.count - tmr.active[k].delay;
      assign hit[k] = (tmr.count >= tmr.active[k].delay) && (since < tmr.active[k].width);
   end

   // same register stage for t0 and pins keeps them aligned
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         t0   <= 1'b0;
         pins <= '0;
      end else begin
         t0   <= tmr.period_start;
         pins <= hit;
      end
   end

endmodule

/* dg_top.sv */
// module: delay generator top, AXI4-Lite ports, register stage, protocol store, timer, pins
`timescale 1ns/1ps

module dg_top
   import dg_pkg::*;
   #(
   parameter int NDELAY_PAIRS     = 9,
   parameter int DEFAULT_INTERVAL = 100000,
   parameter int MIN_INTERVAL     = 1000
   )
   (
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,

   input  logic [ADDR_W-1:0]       awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [DATA_W-1:0]       wdata,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [ADDR_W-1:0]       araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [DATA_W-1:0]       rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,

   output logic                    t0,
   output logic [NDELAY_PAIRS-1:0] pins
   );

   logic [31:0] t0_count;
   logic [63:0] timestamp;

   cfg_bus_if                                 cfg_bus ();
   dg_cfg_if #(.NDELAY_PAIRS(NDELAY_PAIRS))   dg_cfg ();
   timer_if  #(.NDELAY_PAIRS(NDELAY_PAIRS))   tmr ();

   // ================================================
   // host side
   // ================================================
   axil_regs i_axil_regs (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .awaddr           (awaddr),
      .awvalid          (awvalid),
      .awready          (awready),
      .wdata            (wdata),
      .wvalid           (wvalid),
      .wready           (wready),
      .bresp            (bresp),
      .bvalid           (bvalid),
      .bready           (bready),
      .araddr           (araddr),
      .arvalid          (arvalid),
      .arready          (arready),
      .rdata            (rdata),
      .rresp            (rresp),
      .rvalid           (rvalid),
      .rready           (rready),
      .cfg              (cfg_bus.host),
      .t0_count         (t0_count),
      .timestamp        (timestamp)
   );

   protocol_table #(
      .NDELAY_PAIRS     (NDELAY_PAIRS),
      .DEFAULT_INTERVAL (DEFAULT_INTERVAL),
      .MIN_INTERVAL     (MIN_INTERVAL)
   ) i_protocol_table (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .bus              (cfg_bus.store),
      .cfg_out          (dg_cfg.drv)
   );

   // ================================================
   // generator side
   // ================================================
   period_timer #(
      .NDELAY_PAIRS     (NDELAY_PAIRS),
      .DEFAULT_INTERVAL (DEFAULT_INTERVAL)
   ) i_period_timer (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .cfg_in           (dg_cfg.rcv),
      .tmr              (tmr.drv),
      .t0_count         (t0_count),
      .timestamp        (timestamp)
   );

   pulse_channels #(
      .NDELAY_PAIRS     (NDELAY_PAIRS)
   ) i_pulse_channels (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .tmr              (tmr.rcv),
      .t0               (t0),
      .pins             (pins)
   );

endmodule

/* dg_assert.sv */
// checker module and bind: AXI4-Lite response hold, response causes, t0 pulse width
`timescale 1ns/1ps

module dg_assert
   import dg_pkg::*;
   (
   input logic              clk100,
   input logic              hps_fpga_reset_n,
   input logic              awvalid,
   input logic              awready,
   input logic              wvalid,
   input logic              wready,
   input logic [1:0]        bresp,
   input logic              bvalid,
   input logic              bready,
   input logic              arvalid,
   input logic              arready,
   input logic [DATA_W-1:0] rdata,
   input logic [1:0]        rresp,
   input logic              rvalid,
   input logic              rready,
   input logic              t0
   );

   // ================================================
   // response channels under back-pressure
   // ================================================
   a_b_hold: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped or bresp changed while bready was low");

   a_r_hold: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid dropped or read data changed while rready was low");

   // a response only follows an accepted request
   a_b_cause: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
      else $error("bvalid rose without an accepted write");

   a_r_cause: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      $rose(rvalid) |-> $past(arvalid && arready))
      else $error("rvalid rose without an accepted read address");

   a_t0_pulse: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      t0 |=> !t0)
      else $error("t0 stayed high for more than one cycle");

endmodule

bind dg_top dg_assert i_dg_assert (
   .clk100           (clk100),
   .hps_fpga_reset_n (hps_fpga_reset_n),
   .awvalid          (awvalid),
   .awready          (awready),
   .wvalid           (wvalid),
   .wready           (wready),
   .bresp            (bresp),
   .bvalid           (bvalid),
   .bready           (bready),
   .arvalid          (arvalid),
   .arready          (arready),
   .rdata            (rdata),
   .rresp            (rresp),
   .rvalid           (rvalid),
   .rready           (rready),
   .t0               (t0)
);

/* tb_dg_top.sv */
// testbench with clock, reset, AXI4-Lite register access, pulse window model and cycle limit
`timescale 1ns/1ps

module tb_dg_top
   import dg_pkg::*;
   ();

   localparam int NPAIRS  = 3;
   localparam int DEF_IV  = 200;
   localparam int MIN_IV  = 40;
   localparam int NREGS   = 2 * NPAIRS;          // delay and width per channel
   localparam int TIMEOUT = 40 * DEF_IV + 5000;

   logic              clk100;
   logic              hps_fpga_reset_n;
   logic [ADDR_W-1:0] awaddr;
   logic              awvalid;
   logic              awready;
   logic [DATA_W-1:0] wdata;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [ADDR_W-1:0] araddr;
   logic              arvalid;
   logic              arready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;
   logic              t0;
   logic [NPAIRS-1:0] pins;

   integer      seed   = 32'h716f8964;
   int          cycles = 0;
   bit          stall_en;                       // random bready / rready hold-off
   logic [31:0] expected [NPAGES][NREGS];      // host copy of every page

   dg_top #(
      .NDELAY_PAIRS     (NPAIRS),
      .DEFAULT_INTERVAL (DEF_IV),
      .MIN_INTERVAL     (MIN_IV)
   ) i_dg_top (.*);

   initial begin
      clk100 = 1'b0;
      forever #10 clk100 = ~clk100;
   end

   always @(posedge clk100) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout: the test did not finish within %0d cycles", TIMEOUT);
         $display("TEST RESULT: FAIL");
         $fatal(1, "cycle limit reached");
      end
   end

   // ================================================
   // helpers
   // ================================================
   task automatic report_failure(input string msg);
      $display("[FAIL] t=%0t %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
   endtask

   function automatic logic [IDX_W-1:0] chan_idx(input int i);
      return REG_CHAN_BASE + IDX_W'(i);         // delay on even offsets and width on odd ones
   endfunction

   task automatic write_reg(input logic [IDX_W-1:0] idx, input logic [31:0] data);
      int hold;
      @(posedge clk100);
      awaddr  <= {idx, 2'b00};
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do @(posedge clk100); while (!(awready && wready));   // accepted with both readies
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      hold = stall_en ? int'($unsigned($random(seed)) % 6) : 0;
      repeat (hold) @(posedge clk100);
      bready <= 1'b1;
      do @(posedge clk100); while (!bvalid);
      bready <= 1'b0;
      assert (bresp == RESP_OKAY)
         else report_failure($sformatf("write to reg %0d answered bresp %0b", idx, bresp));
   endtask

   task automatic read_reg(input logic [IDX_W-1:0] idx, output logic [31:0] data);
      int hold;
      @(posedge clk100);
      araddr  <= {idx, 2'b00};
      arvalid <= 1'b1;
      do @(posedge clk100); while (!arready);
      arvalid <= 1'b0;
      hold = stall_en ? int'($unsigned($random(seed)) % 6) : 0;
      repeat (hold) @(posedge clk100);
      rready <= 1'b1;
      do @(posedge clk100); while (!rvalid);
      rready <= 1'b0;
      data = rdata;
      assert (rresp == RESP_OKAY)
         else report_failure($sformatf("read of reg %0d answered rresp %0b", idx, rresp));
   endtask

   task automatic expect_reg(input logic [IDX_W-1:0] idx, input logic [31:0] exp,
                             input string what);
      logic [31:0] got;
      read_reg(idx, got);
      assert (got == exp)
         else report_failure($sformatf("%s: reg %0d read %h, expected %h", what, idx, got, exp));
   endtask

   task automatic load_page(input int p);
      write_reg(REG_FLAGS, 32'(p));
      for (int i = 0; i < NREGS; i++) begin
         write_reg(chan_idx(i), expected[p][i]);
      end
   endtask

   task automatic verify_page(input int p);
      write_reg(REG_FLAGS, 32'(p));
      for (int i = 0; i < NREGS; i++) begin
         expect_reg(chan_idx(i), expected[p][i], $sformatf("page %0d", p));
      end
   endtask

   task automatic verify_committed(input int p);
      write_reg(REG_FLAGS, 32'h4);              // view bit set
      for (int i = 0; i < NREGS; i++) begin
         expect_reg(chan_idx(i), expected[p][i], "committed view");
      end
   endtask

   task automatic wait_for_t0();
      do @(negedge clk100); while (!t0);
   endtask

   // pin model with n counting cycles since the last t0
   task automatic check_windows(input int pg, input int interval, input int nper);
      int          n;
      int          seen;
      logic [63:0] lo;
      logic [63:0] hi;
      logic        want;
      wait_for_t0();
      n    = 0;
      seen = 0;
      while (seen < nper) begin
         for (int k = 0; k < NPAIRS; k++) begin
            lo   = 64'(expected[pg][2*k]);
            hi   = lo + 64'(expected[pg][2*k+1]);
            want = (64'(n) >= lo) && (64'(n) < hi);
            assert (pins[k] == want)
               else report_failure($sformatf("pin %0d at n=%0d is %0b, window [%0d,%0d)",
                                             k, n, pins[k], lo, hi));
         end
         @(negedge clk100);
         n++;
         if (t0) begin
            assert (n == interval)
               else report_failure($sformatf("t0 spacing %0d, expected %0d", n, interval));
            n = 0;
            seen++;
         end
      end
   endtask

   // ================================================
   // stimulus
   // ================================================
   initial begin
      logic [31:0] cnt_a;
      logic [31:0] cnt_b;
      logic [63:0] ts_a;
      logic [63:0] ts_b;

      hps_fpga_reset_n <= 1'b0;
      awaddr           <= '0;
      awvalid          <= 1'b0;
      wdata            <= '0;
      wvalid           <= 1'b0;
      bready           <= 1'b0;
      araddr           <= '0;
      arvalid          <= 1'b0;
      rready           <= 1'b0;
      stall_en = 1'b0;
      for (int p = 0; p < NPAGES; p++) begin
         for (int i = 0; i < NREGS; i++) begin
            expected[p][i] = '0;
         end
      end

      repeat (15) @(posedge clk100);
      @(negedge clk100);
      assert (!t0 && pins == '0 && !bvalid && !rvalid)
         else report_failure("outputs not low during reset");
      @(posedge clk100);
      hps_fpga_reset_n <= 1'b1;

      // reset values and unmapped reads
      for (int i = 0; i < NREGS; i++) begin
         expect_reg(chan_idx(i), '0, "channel after reset");
      end
      expect_reg(REG_INTERVAL, '0, "setpoint after reset");
      write_reg(REG_FLAGS, 32'h4);
      expect_reg(REG_INTERVAL, 32'(DEF_IV), "committed interval after reset");
      for (int i = 0; i < NREGS; i++) begin
         expect_reg(chan_idx(i), '0, "committed channel after reset");
      end
      expect_reg(REG_MODEL, MODEL_NUMBER, "model number");
      expect_reg(IDX_W'(8), '0, "unmapped");
      expect_reg(IDX_W'(15), '0, "unmapped");
      expect_reg(chan_idx(NREGS), '0, "unmapped above channels");
      expect_reg(IDX_W'(63), '0, "unmapped");
      write_reg(REG_FLAGS, '0);
      check_windows(3, DEF_IV, 2);             // reset set is all zero just like unused page 3

      // full words on page 0 and short windows on page 2 for the pin model
      for (int i = 0; i < NREGS; i++) begin
         expected[0][i] = $random(seed);
         expected[2][i] = $unsigned($random(seed)) % ((i % 2) ? 32 : 48);
      end
      load_page(0);
      load_page(2);
      verify_page(2);
      verify_page(0);

      // commit protocol 2 with a setpoint below the minimum
      write_reg(REG_INTERVAL, 32'd10);
      write_reg(REG_PROTOCOL, 32'd2);
      write_reg(REG_COMMIT, 32'd1);
      verify_committed(2);
      expect_reg(REG_INTERVAL, 32'(MIN_IV), "clamped committed interval");
      write_reg(REG_FLAGS, '0);
      expect_reg(REG_INTERVAL, 32'd10, "interval setpoint");
      expect_reg(REG_FLAGS, '0, "flags");
      expect_reg(REG_PROTOCOL, 32'd2, "protocol select");

      wait_for_t0();                           // may still close an old period
      check_windows(2, MIN_IV, 6);

      // ================================================
      // t0 count and timestamp
      // ================================================
      wait_for_t0();
      read_reg(REG_T0_COUNT, cnt_a);
      read_reg(REG_TS_LO, ts_a[31:0]);
      read_reg(REG_TS_HI, ts_a[63:32]);
      wait_for_t0();
      read_reg(REG_T0_COUNT, cnt_b);
      read_reg(REG_TS_LO, ts_b[31:0]);
      read_reg(REG_TS_HI, ts_b[63:32]);
      assert (cnt_b == cnt_a + 32'd1)
         else report_failure($sformatf("t0 count %0d then %0d", cnt_a, cnt_b));
      assert (ts_b - ts_a == 64'(MIN_IV))
         else report_failure($sformatf("timestamp step %0d, expected %0d", ts_b - ts_a, MIN_IV));

      read_reg(REG_T0_COUNT, cnt_a);
      repeat (5) wait_for_t0();
      read_reg(REG_T0_COUNT, cnt_b);
      assert (cnt_b - cnt_a == 32'd5)
         else report_failure($sformatf("t0 count grew by %0d over 5 pulses", cnt_b - cnt_a));

      // back-pressure on both response channels
      stall_en = 1'b1;
      for (int i = 0; i < NREGS; i++) begin
         expected[0][i] = $random(seed);       // new words for page 0
      end
      load_page(0);
      verify_page(2);
      verify_page(0);
      verify_committed(2);
      stall_en = 1'b0;

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* sim.f */
dg_pkg.sv
cfg_bus_if.sv
dg_cfg_if.sv
axil_regs.sv
protocol_table.sv
period_timer.sv
pulse_channels.sv
dg_top.sv
dg_assert.sv
tb_dg_top.sv

/* run_sim.sh */
#!/bin/sh
# build the delay generator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_dg_top \
   -f sim.f \
   -o sim_dg

./obj_dir/sim_dg
